// File: tb.f
verilog/cpuPkg.sv
verilog/ctrlIf.sv
verilog/cpuSequencer.sv
verilog/progCounter.sv
verilog/regFile.sv
verilog/aluExec.sv
verilog/wordMem.sv
verilog/cpuTop.sv
sim/cpuTop_chk.sv
sim/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpuTb
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: sim/cpuTb.sv
// Core testbench with ISA model
module cpuTb;
   timeunit 1ns;
   timeprecision 100ps;
   import cpuPkg::*;

   localparam int numProgs      = 20;
   localparam int progLen       = 40;     // Random slots before the closing HALT
   localparam int timeoutCycles = numProgs * (memDepth + (progLen + 1) * 5 + 20);

   typedef struct packed {
      wordT   pc;
      logic   regWe;
      regIdxT dest;
      wordT   data;
      logic   memWe;
      wordT   memAddr;
      wordT   memData;
   } retireT;

   logic   clk, arstN, run, progWe;
   wordT   progAddr, progData;
   logic   retireValid, retireRegWe, retireMemWe, halt, err;
   regIdxT retireDest;
   wordT   retirePc, retireData, retireMemAddr, retireMemData;

   wordT   prog [memDepth];               // Instruction memory image
   wordT   mReg [8];                      // Model registers
   wordT   mMem [memDepth];               // Model data memory, survives reset like the DUT's
   bit     mValid [memDepth];             // Word written by some ST
   retireT expQ [$];                      // Expected retire trace
   logic   expErr;                        // Program ends in the trap
   int     cycles;
   int     pcErrs, regErrs, memErrs, flagErrs, otherErrs;

   cpuTop i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeoutCycles) begin
         $display("Timeout: no halt after %0d cycles", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   task automatic checkPc(input wordT got, input wordT exp);
      if (got !== exp) begin
         pcErrs++;
         $display("CHECK FAILED retirePc: got %h expected %h", got, exp);
      end
   endtask

   task automatic checkReg(input logic weGot, input regIdxT idxGot, input wordT dataGot,
                           input logic weExp, input regIdxT idxExp, input wordT dataExp);
      if (weGot !== weExp) begin
         regErrs++;
         $display("CHECK FAILED retireRegWe: got %h expected %h", weGot, weExp);
      end else if (weExp && (idxGot !== idxExp || dataGot !== dataExp)) begin
         regErrs++;
         $display("CHECK FAILED retireDest/retireData: got %h/%h expected %h/%h",
                  idxGot, dataGot, idxExp, dataExp);
      end
   endtask

   task automatic checkMem(input logic weGot, input wordT addrGot, input wordT dataGot,
                           input logic weExp, input wordT addrExp, input wordT dataExp);
      if (weGot !== weExp) begin
         memErrs++;
         $display("CHECK FAILED retireMemWe: got %h expected %h", weGot, weExp);
      end else if (weExp && (addrGot !== addrExp || dataGot !== dataExp)) begin
         memErrs++;
         $display("CHECK FAILED retireMemAddr/retireMemData: got %h/%h expected %h/%h",
                  addrGot, dataGot, addrExp, dataExp);
      end
   endtask

   task automatic checkFlags(input logic haltGot, input logic errGot,
                             input logic haltExp, input logic errExp);
      if (haltGot !== haltExp || errGot !== errExp) begin
         flagErrs++;
         $display("CHECK FAILED halt/err: got %h/%h expected %h/%h",
                  haltGot, errGot, haltExp, errExp);
      end
   endtask

   function automatic bit isLegal(input logic [4:0] op);
      case (op)
         opHalt, opNop, opJ, opAddi, opSubi, opXori, opBeqz, opBnez, opSt, opLd, opRtype:
            return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [4:0] illegalOp();
      logic [4:0] op;
      op = 5'($urandom);
      while (isLegal(op)) op = 5'($urandom); // Redraw until outside the ISA
      return op;
   endfunction

   function automatic wordT randomInstr(input int slot);
      wordT w;
      int   room;
      room = progLen - 1 - slot;          // Slots up to and including HALT, minus one
      if (room > 5) room = 5;
      w = wordT'($urandom);               // Random fields, opcode replaced below
      case ($urandom_range(0, 10))
         0: w[15:11] = opNop;
         1, 2: w[15:11] = opAddi;
         3: w[15:11] = opSubi;
         4: w[15:11] = opXori;
         5: w[15:11] = opLd;
         6: w[15:11] = opSt;
         7: w[15:11] = opRtype;
         8, 9: begin
            w[15:11] = $urandom_range(0, 1) ? opBnez : opBeqz;
            w[7:0]   = 8'(2 * $urandom_range(0, room)); // Forward, lands by HALT
         end
         default: begin
            w[15:11] = opJ;
            w[10:0]  = 11'(2 * $urandom_range(0, room));
         end
      endcase
      return w;
   endfunction

   // One instruction of the ISA model, appends its retire record
   task automatic modelStep(input int slot, inout wordT ins, output int nextSlot);
      opcodeT             op;
      regIdxT             rs, rd;
      wordT               pc, imm5, addr, res, disp, nextPc;
      logic               taken;
      logic [memIdxW-1:0] idx;
      op     = opcodeT'(ins[15:11]);
      rs     = ins[10:8];
      rd     = ins[7:5];
      pc     = wordT'(2 * slot);
      imm5   = {{11{ins[4]}}, ins[4:0]};
      addr   = mReg[rs] + imm5;
      idx    = addr[memIdxW:1];           // Word index, bit 0 dropped
      nextPc = pc + 16'd2;
      if (op == opLd && !mValid[idx]) begin
         op         = opSt;               // Unwritten word, turn into a store
         ins[15:11] = opSt;
      end
      case (op)
         opAddi, opSubi, opXori: begin
            if (op == opAddi) res = mReg[rs] + imm5;
            else if (op == opSubi) res = mReg[rs] - imm5;
            else res = mReg[rs] ^ imm5;
            mReg[rd] = res;
            expQ.push_back('{pc, 1'b1, rd, res, 1'b0, 16'h0, 16'h0});
         end
         opLd: begin
            mReg[rd] = mMem[idx];
            expQ.push_back('{pc, 1'b1, rd, mMem[idx], 1'b0, 16'h0, 16'h0});
         end
         opSt: begin
            mMem[idx]   = mReg[rd];
            mValid[idx] = 1'b1;
            expQ.push_back('{pc, 1'b0, 3'd0, 16'h0, 1'b1, addr, mReg[rd]});
         end
         opRtype: begin
            case (ins[1:0])
               2'd0:    res = mReg[rs] + mReg[rd];
               2'd1:    res = mReg[rs] - mReg[rd];
               2'd2:    res = mReg[rs] ^ mReg[rd];
               default: res = mReg[rs] & mReg[rd];
            endcase
            mReg[ins[4:2]] = res;
            expQ.push_back('{pc, 1'b1, ins[4:2], res, 1'b0, 16'h0, 16'h0});
         end
         opBeqz, opBnez, opJ: begin
            taken = (op == opJ) || ((mReg[rs] == '0) == (op == opBeqz));
            disp  = (op == opJ) ? {{5{ins[10]}}, ins[10:0]} : {{8{ins[7]}}, ins[7:0]};
            if (taken) nextPc = pc + 16'd2 + disp;
            expQ.push_back('{pc, 1'b0, 3'd0, 16'h0, 1'b0, 16'h0, 16'h0});
         end
         default: expQ.push_back('{pc, 1'b0, 3'd0, 16'h0, 1'b0, 16'h0, 16'h0}); // NOP, HALT
      endcase
      nextSlot = int'(nextPc[15:1]);
   endtask

   task automatic genProgram(input bit inject);
      int   execSlot;
      int   nExec;
      int   trapAt;
      wordT ins;
      for (int i = 0; i < memDepth; i++) prog[i] = {opHalt, 11'(i)}; // HALT fill
      for (int r = 0; r < 8; r++) mReg[r] = '0;
      expQ.delete();
      expErr   = 1'b0;
      execSlot = 0;
      nExec    = 0;
      trapAt   = inject ? int'($urandom_range(0, 15)) : -1;
      for (int i = 0; i < progLen; i++) begin
         ins = randomInstr(i);
         if (i == execSlot) begin
            if (nExec == trapAt) begin
               ins[15:11] = illegalOp();
               expErr     = 1'b1;
               execSlot   = -1;           // Nothing more executes
            end else begin
               modelStep(i, ins, execSlot);
               nExec++;
            end
         end
         prog[i] = ins;                   // Skipped slots stay random
      end
      if (execSlot == progLen && inject) begin
         prog[progLen][15:11] = illegalOp(); // Trap not reached, put it on HALT
         expErr               = 1'b1;
      end else if (execSlot == progLen) begin
         ins = prog[progLen];
         modelStep(progLen, ins, execSlot);
      end
   endtask

   task automatic applyReset();
      @(negedge clk);
      arstN  = 1'b0;
      run    = 1'b0;
      progWe = 1'b0;
      repeat (8) @(negedge clk);
      arstN = 1'b1;
   endtask

   task automatic loadProgram();
      for (int i = 0; i < memDepth; i++) begin
         progWe   = 1'b1;
         progAddr = wordT'(2 * i);
         progData = prog[i];
         @(negedge clk);
      end
      progWe = 1'b0;
   endtask

   task automatic checkRetire();
      retireT e;
      if (expQ.size() == 0) begin
         otherErrs++;
         $display("Unexpected retire at PC %h after the model's last instruction", retirePc);
      end else begin
         e = expQ.pop_front();
         checkPc(retirePc, e.pc);
         checkReg(retireRegWe, retireDest, retireData, e.regWe, e.dest, e.data);
         checkMem(retireMemWe, retireMemAddr, retireMemData, e.memWe, e.memAddr, e.memData);
      end
   endtask

   initial begin
      void'($urandom(32'h3ca7));
      arstN    = 1'b0;
      run      = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      for (int p = 0; p < numProgs; p++) begin
         genProgram(p % 4 == 3);          // Every fourth program traps
         applyReset();
         @(negedge clk);
         checkFlags(halt, err, 1'b0, 1'b0);
         if (retireValid) begin
            otherErrs++;
            $display("retireValid is high right after reset");
         end
         loadProgram();
         run = 1'b1;
         while (!halt) begin
            @(negedge clk);
            if (retireValid) checkRetire();
         end
         checkFlags(halt, err, 1'b1, expErr);
         if (expQ.size() != 0) begin
            otherErrs++;
            $display("Program %0d halted with %0d instructions not retired", p, expQ.size());
         end
         repeat (6) begin
            @(negedge clk);
            if (retireValid) begin
               otherErrs++;
               $display("Instruction retired after halt in program %0d", p);
            end
         end
      end
      $display("Errors: pc %0d, reg %0d, mem %0d, flags %0d, other %0d",
               pcErrs, regErrs, memErrs, flagErrs, otherErrs);
      if (pcErrs + regErrs + memErrs + flagErrs + otherErrs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: sim/cpuTop_chk.sv
// Retire and halt protocol assertions
module cpuTop_chk (
   input logic clk,
   input logic arstN,
   input logic retireValid,
   input logic retireRegWe,
   input logic retireMemWe,
   input logic halt,
   input logic err
);
   timeunit 1ns;
   timeprecision 100ps;

   retireOnePulse: assert property (@(posedge clk) disable iff (!arstN)
      retireValid |=> !retireValid) else $error("retireValid high two cycles in a row");

   noRetireHalted: assert property (@(posedge clk) disable iff (!arstN)
      halt |-> !retireValid) else $error("Instruction retired while halted");

   errHalts: assert property (@(posedge clk) disable iff (!arstN)
      err |-> halt) else $error("err high without halt");

   errSticky: assert property (@(posedge clk) disable iff (!arstN)
      err |=> err) else $error("err dropped before reset");

   enablesInRetire: assert property (@(posedge clk) disable iff (!arstN)
      (retireRegWe || retireMemWe) |-> retireValid) else $error("Write enable outside retire");

endmodule

bind cpuTop cpuTop_chk i_chk (
   .clk(clk), .arstN(arstN), .retireValid(retireValid), .retireRegWe(retireRegWe),
   .retireMemWe(retireMemWe), .halt(halt), .err(err)
);

// File: verilog/cpuTop.sv
// Multi-cycle core top
module cpuTop (
   input  logic           clk,
   input  logic           arstN,
   input  logic           run,           // Start executing from PC 0
   input  logic           progWe,        // Program load, IDLE only
   input  cpuPkg::wordT   progAddr,
   input  cpuPkg::wordT   progData,
   output logic           retireValid,
   output cpuPkg::wordT   retirePc,
   output logic           retireRegWe,
   output cpuPkg::regIdxT retireDest,
   output cpuPkg::wordT   retireData,
   output logic           retireMemWe,
   output cpuPkg::wordT   retireMemAddr,
   output cpuPkg::wordT   retireMemData,
   output logic           halt,
   output logic           err
);
   import cpuPkg::*;

   ctrlIf ctrl ();

   logic fetchEn, decodeEn, execEn, memEn, retire;
   logic taken;
   logic loadOpen;                       // Mirrors IDLE, closes on first fetch
   wordT pc, instr;
   wordT valA, valB;
   wordT aluResult, memData, wbData;
   wordT curPc, stAddr, stData;          // Trace copies

   cpuSequencer u_seq (
      .clk, .arstN, .run, .instr, .ctrl(ctrl.seq),
      .fetchEn, .decodeEn, .execEn, .memEn, .retire, .halt, .err
   );

   progCounter u_pc (.clk, .arstN, .retire, .taken, .disp(ctrl.imm), .pc);

   regFile u_regs (
      .clk, .arstN, .rdA(instr[10:8]), .rdB(instr[7:5]), .valA, .valB,
      .we(retire & ctrl.regWrite), .wrIdx(ctrl.regDest), .wrData(wbData)
   );

   aluExec u_alu (
      .clk, .arstN, .execEn, .ctrl(ctrl.dp), .valA, .valB,
      .result(aluResult), .taken
   );

   wordMem #(.depth(memDepth)) instrMem (
      .clk, .re(fetchEn), .addr(pc), .rdata(instr),
      .we(progWe & loadOpen), .waddr(progAddr), .wdata(progData)
   );

   wordMem #(.depth(memDepth)) dataMem (
      .clk, .re(memEn & ctrl.memRead), .addr(aluResult), .rdata(memData),
      .we(memEn & ctrl.memWrite), .waddr(aluResult), .wdata(valB)
   );

   assign wbData = ctrl.memToReg ? memData : aluResult; // LD or ALU

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         loadOpen <= 1'b1;
      end else if (fetchEn) begin
         loadOpen <= 1'b0;               // Core left IDLE
      end
   end

   always_ff @(posedge clk) begin
      if (fetchEn) curPc <= pc;          // PC of this instruction
      if (decodeEn) stData <= valB;      // Store data register
      if (memEn) stAddr <= aluResult;    // Effective address
   end

   assign retireValid   = retire;
   assign retirePc      = curPc;
   assign retireRegWe   = retire & ctrl.regWrite;
   assign retireDest    = ctrl.regDest;
   assign retireData    = wbData;
   assign retireMemWe   = retire & ctrl.memWrite;
   assign retireMemAddr = stAddr;
   assign retireMemData = stData;

endmodule

// File: verilog/wordMem.sv
// Synchronous word memory
module wordMem #(
   parameter int depth = cpuPkg::memDepth
) (
   input  logic         clk,
   input  logic         re,              // Read strobe, data next cycle
   input  cpuPkg::wordT addr,            // Byte address
   output cpuPkg::wordT rdata,           // Held until the next read
   input  logic         we,
   input  cpuPkg::wordT waddr,
   input  cpuPkg::wordT wdata
);
   import cpuPkg::*;

   localparam int idxW = $clog2(depth);

   wordT mem [depth];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr[idxW:1]] <= wdata;    // Bit 0 ignored
      end
      if (re) begin
         rdata <= mem[addr[idxW:1]];
      end
   end

endmodule

// File: verilog/aluExec.sv
// ALU and branch unit
module aluExec (
   input  logic         clk,
   input  logic         arstN,
   input  logic         execEn,          // EXECUTE cycle
   ctrlIf.dp            ctrl,
   input  cpuPkg::wordT valA,            // rs
   input  cpuPkg::wordT valB,            // rt
   output cpuPkg::wordT result,          // Registered ALU output
   output logic         taken            // Registered branch decision
);
   import cpuPkg::*;

   wordT opB;
   wordT aluOut;
   logic takenNext;

   assign opB = ctrl.aluSrcImm ? ctrl.imm : valB; // Immediate or register

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:  aluOut = valA + opB;   // Also LD/ST address
         aluSub:  aluOut = valA - opB;
         aluXor:  aluOut = valA ^ opB;
         aluAnd:  aluOut = valA & opB;
         default: aluOut = opB;
      endcase
   end

   // Condition on rs only
   always_comb begin
      case (ctrl.branch)
         brEqz:   takenNext = valA == '0;
         brNez:   takenNext = valA != '0;
         brJump:  takenNext = 1'b1;
         default: takenNext = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         taken <= 1'b0;
      end else if (execEn) begin
         taken <= takenNext;
      end
   end

   always_ff @(posedge clk) begin
      if (execEn) begin
         result <= aluOut;
      end
   end

endmodule

// File: verilog/regFile.sv
// General-purpose registers
module regFile (
   input  logic           clk,
   input  logic           arstN,
   input  cpuPkg::regIdxT rdA,           // rs
   input  cpuPkg::regIdxT rdB,           // rt or store data register
   output cpuPkg::wordT   valA,
   output cpuPkg::wordT   valB,
   input  logic           we,            // Writeback strobe
   input  cpuPkg::regIdxT wrIdx,
   input  cpuPkg::wordT   wrData
);
   import cpuPkg::*;

   wordT regs [8];

   // Reads are combinational, a write lands on the retire edge
   assign valA = regs[rdA];
   assign valB = regs[rdB];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;               // All registers start at zero
         end
      end else if (we) begin
         regs[wrIdx] <= wrData;
      end
   end

endmodule

// File: verilog/progCounter.sv
// Program counter
module progCounter (
   input  logic         clk,
   input  logic         arstN,
   input  logic         retire,          // Advance at the end of an instruction
   input  logic         taken,           // Registered branch decision
   input  cpuPkg::wordT disp,            // Sign-extended displacement
   output cpuPkg::wordT pc
);
   import cpuPkg::*;

   wordT pcPlusTwo;
   wordT pcNext;

   assign pcPlusTwo = pc + 16'd2;        // Byte address, word step
   assign pcNext    = taken ? pcPlusTwo + disp : pcPlusTwo;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;                       // Program starts at 0
      end else if (retire) begin
         pc <= pcNext;
      end
   end

endmodule

// File: verilog/cpuSequencer.sv
// Instruction sequencer
module cpuSequencer (
   input  logic         clk,
   input  logic         arstN,
   input  logic         run,
   input  cpuPkg::wordT instr,           // Instruction memory output, stable from DECODE
   ctrlIf.seq           ctrl,
   output logic         fetchEn,
   output logic         decodeEn,
   output logic         execEn,
   output logic         memEn,
   output logic         retire,
   output logic         halt,
   output logic         err
);
   import cpuPkg::*;

   typedef enum logic [2:0] {
      sIdle,
      sFetch,
      sDecode,
      sExecute,
      sMemory,
      sWriteback,
      sHalted,
      sError
   } stateT;

   stateT  state;
   stateT  stateNext;
   opcodeT opcode;
   logic   legal;                         // Opcode is one of opcodeT
   logic   isMem;                         // Latched in DECODE, adds MEMORY cycle
   logic   isHalt;                        // Latched in DECODE, ends in HALTED

   assign opcode = opcodeT'(instr[15:11]);

   // Control word decode
   always_comb begin
      legal          = 1'b1;
      ctrl.aluOp     = aluPassB;
      ctrl.aluSrcImm = 1'b0;
      ctrl.imm       = {{11{instr[4]}}, instr[4:0]}; // imm5 sign-extended
      ctrl.branch    = brNone;
      ctrl.memRead   = 1'b0;
      ctrl.memWrite  = 1'b0;
      ctrl.memToReg  = 1'b0;
      ctrl.regWrite  = 1'b0;
      ctrl.regDest   = instr[7:5];       // I-type rd
      case (opcode)
         opHalt, opNop: legal = 1'b1;    // No datapath effect
         opAddi, opSubi, opXori: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            case (opcode)
               opSubi:  ctrl.aluOp = aluSub;
               opXori:  ctrl.aluOp = aluXor;
               default: ctrl.aluOp = aluAdd;
            endcase
         end
         opLd: begin
            ctrl.aluOp     = aluAdd;     // Address rs + imm
            ctrl.aluSrcImm = 1'b1;
            ctrl.memRead   = 1'b1;
            ctrl.memToReg  = 1'b1;
            ctrl.regWrite  = 1'b1;
         end
         opSt: begin
            ctrl.aluOp     = aluAdd;
            ctrl.aluSrcImm = 1'b1;
            ctrl.memWrite  = 1'b1;       // Data comes from r[7:5]
         end
         opRtype: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDest  = instr[4:2];  // R-type rd
            case (instr[1:0])
               2'd0:    ctrl.aluOp = aluAdd;
               2'd1:    ctrl.aluOp = aluSub;
               2'd2:    ctrl.aluOp = aluXor;
               default: ctrl.aluOp = aluAnd;
            endcase
         end
         opBeqz, opBnez: begin
            ctrl.imm    = {{8{instr[7]}}, instr[7:0]}; // disp8
            ctrl.branch = (opcode == opBeqz) ? brEqz : brNez;
         end
         opJ: begin
            ctrl.imm    = {{5{instr[10]}}, instr[10:0]}; // disp11
            ctrl.branch = brJump;
         end
         default: legal = 1'b0;          // Trap
      endcase
   end

   always_comb begin
      stateNext = state;
      case (state)
         sIdle:      if (run) stateNext = sFetch;
         sFetch:     stateNext = sDecode;
         sDecode:    stateNext = legal ? sExecute : sError;
         sExecute:   stateNext = isMem ? sMemory : sWriteback;
         sMemory:    stateNext = sWriteback;
         sWriteback: stateNext = isHalt ? sHalted : sFetch;
         default:    stateNext = state;  // HALTED and ERROR hold until reset
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state  <= sIdle;
         isMem  <= 1'b0;
         isHalt <= 1'b0;
      end else begin
         state <= stateNext;
         if (state == sDecode) begin    // Keep the instruction class
            isMem  <= (opcode == opLd) || (opcode == opSt);
            isHalt <= opcode == opHalt;
         end
      end
   end

   assign fetchEn  = state == sFetch;
   assign decodeEn = state == sDecode;
   assign execEn   = state == sExecute;
   assign memEn    = state == sMemory;
   assign retire   = state == sWriteback; // One cycle per instruction
   assign halt     = (state == sHalted) || (state == sError);
   assign err      = state == sError;

endmodule

// File: verilog/ctrlIf.sv
// Decoded control word
interface ctrlIf;
   import cpuPkg::*;

   aluOpT  aluOp;                         // ALU operation
   logic   aluSrcImm;                     // Operand B from immediate
   wordT   imm;                           // Sign-extended immediate or displacement
   branchT branch;                        // Branch kind
   logic   memRead;                       // LD
   logic   memWrite;                      // ST
   logic   memToReg;                      // Writeback takes memory data
   logic   regWrite;                      // Instruction writes a register
   regIdxT regDest;                       // Destination register

   modport seq (                          // Driven by the sequencer
      output aluOp, aluSrcImm, imm, branch,
      output memRead, memWrite, memToReg,
      output regWrite, regDest
   );

   modport dp (                           // Read by the datapath
      input aluOp, aluSrcImm, imm, branch,
      input memRead, memWrite, memToReg,
      input regWrite, regDest
   );

endinterface

// File: verilog/cpuPkg.sv
// Core types and constants
package cpuPkg;

   typedef logic [15:0] wordT;            // Data, address and instruction word
   typedef logic [2:0]  regIdxT;          // Register number r0..r7

   // Instruction fields
   //   rs       instr[10:8]
   //   I-type   rd instr[7:5], imm5 instr[4:0]
   //   R-type   rt instr[7:5], rd instr[4:2], funct instr[1:0]
   //   Branch   disp8 instr[7:0]
   //   J        disp11 instr[10:0]

   typedef enum logic [4:0] {
      opHalt  = 5'b00000,                 // Stop the core
      opNop   = 5'b00001,
      opJ     = 5'b00100,                 // PC + 2 + disp11
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,                 // rs - imm
      opXori  = 5'b01010,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,                 // mem[rs + imm] = r[7:5]
      opLd    = 5'b10001,                 // r[7:5] = mem[rs + imm]
      opRtype = 5'b11011                  // Funct picks ADD, SUB, XOR, AND
   } opcodeT;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluAnd,
      aluPassB                            // Operand B straight through
   } aluOpT;

   typedef enum logic [1:0] {
      brNone,                             // Fall through to PC + 2
      brEqz,                              // Taken when rs is zero
      brNez,                              // Taken when rs is nonzero
      brJump                              // Always taken
   } branchT;

   localparam int memDepth = 256;             // Words per memory
   localparam int memIdxW  = $clog2(memDepth); // Word index, taken from addr bits above bit 0

endpackage
